// ==== list.f ====
rtl/simd_op_pkg.sv
rtl/simd_data_pkg.sv
rtl/simd_compare.sv
rtl/simd_addsub.sv
rtl/simd_shift.sv
rtl/simd_writeback.sv
rtl/simd_alu.sv
sim/tb_clock_gen.sv
sim/simd_alu_asserts.sv
sim/tb_simd_alu.sv

// ==== rtl/simd_addsub.sv ====
`timescale 1ns/10ps

module simd_addsub (
  input  simd_data_pkg::alu_req_t    req_i,
  output simd_data_pkg::elen_t       result_o,
  output simd_data_pkg::byte_flags_t sat_o
);
  import simd_data_pkg::*;
  import simd_op_pkg::*;

  elen_t       [NUM_EW-1:0] res_ew;
  byte_flags_t [NUM_EW-1:0] sat_ew;

  ////////////////////////////////////////////////////////////////////////////
  // Lane adders for every width in parallel
  ////////////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_EW; w++) begin : g_ew
    for (genvar l = 0; l < (NUM_BYTES >> w); l++) begin : g_lane
      logic [ew_bits(w)-1:0] lane_a;
      logic [ew_bits(w)-1:0] lane_b;
      logic [ew_bits(w)-1:0] sum;
      logic [ew_bits(w)-1:0] dif;
      logic [ew_bits(w)-1:0] res;
      logic                  carry;
      logic                  borrow;
      logic                  sign_a;
      logic                  sign_b;
      logic                  sat;

      assign lane_a = req_i.operand_a[l*ew_bits(w) +: ew_bits(w)];
      assign lane_b = req_i.operand_b[l*ew_bits(w) +: ew_bits(w)];
      assign sign_a = lane_a[ew_bits(w)-1];
      assign sign_b = lane_b[ew_bits(w)-1];

      // Subtract is B minus A
      assign {carry, sum}  = {1'b0, lane_a} + {1'b0, lane_b};
      assign {borrow, dif} = {1'b0, lane_b} - {1'b0, lane_a};

      always_comb begin
        res = '0;
        sat = 1'b0;
        case (req_i.op)
          VADD:  res = sum;
          VSUB:  res = dif;
          VRSUB: res = lane_a - lane_b;
          VSADDU: begin
            sat = carry;
            res = carry ? '1 : sum;
          end
          VSADD: begin
            // Same-sign inputs whose sum flips sign
            sat = (sign_a == sign_b) && (sum[ew_bits(w)-1] != sign_a);
            res = sat ? {sign_a, {(ew_bits(w)-1){~sign_a}}} : sum;
          end
          VSSUBU: begin
            sat = borrow;
            res = borrow ? '0 : dif;
          end
          VSSUB: begin
            // True difference keeps the sign of B on overflow
            sat = (sign_a != sign_b) && (dif[ew_bits(w)-1] != sign_b);
            res = sat ? {sign_b, {(ew_bits(w)-1){~sign_b}}} : dif;
          end
          default: ;
        endcase
      end

      assign res_ew[w][l*ew_bits(w) +: ew_bits(w)] = res;
      // Flag covers every byte of the lane
      assign sat_ew[w][l*(1 << w) +: (1 << w)]     = {(1 << w){sat}};
    end
  end

  assign result_o = res_ew[req_i.vew];
  assign sat_o    = sat_ew[req_i.vew];

endmodule

// ==== rtl/simd_alu.sv ====
`timescale 1ns/10ps

module simd_alu (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  simd_data_pkg::alu_req_t    req_i,
  output logic                       valid_o,
  output simd_data_pkg::elen_t       result_o,
  output simd_data_pkg::byte_flags_t vxsat_o
);
  import simd_data_pkg::*;

  byte_flags_t less;
  byte_flags_t equal;
  elen_t       addsub_res;
  byte_flags_t sat;
  elen_t       shift_res;

  // Combinational lane units
  simd_compare u_compare (
    .req_i   (req_i),
    .less_o  (less),
    .equal_o (equal)
  );

  simd_addsub u_addsub (
    .req_i    (req_i),
    .result_o (addsub_res),
    .sat_o    (sat)
  );

  simd_shift u_shift (
    .req_i    (req_i),
    .result_o (shift_res)
  );

  // Result select and output register
  simd_writeback u_writeback (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .less_i   (less),
    .equal_i  (equal),
    .addsub_i (addsub_res),
    .sat_i    (sat),
    .shift_i  (shift_res),
    .valid_o  (valid_o),
    .result_o (result_o),
    .vxsat_o  (vxsat_o)
  );

endmodule

// ==== rtl/simd_compare.sv ====
`timescale 1ns/10ps

module simd_compare (
  input  simd_data_pkg::alu_req_t    req_i,
  output simd_data_pkg::byte_flags_t less_o,
  output simd_data_pkg::byte_flags_t equal_o
);
  import simd_data_pkg::*;
  import simd_op_pkg::*;

  logic                     is_signed;
  byte_flags_t [NUM_EW-1:0] less_ew;
  byte_flags_t [NUM_EW-1:0] equal_ew;

  assign is_signed = is_signed_op(req_i.op);

  ////////////////////////////////////////////////////////////////////////////
  // Lane compares for every width in parallel
  ////////////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_EW; w++) begin : g_ew
    for (genvar i = 0; i < NUM_BYTES; i++) begin : g_byte
      if ((i % (1 << w)) == 0) begin : g_lane
        // Lane starting at this byte
        logic [ew_bits(w)-1:0] lane_a;
        logic [ew_bits(w)-1:0] lane_b;
        logic                  ext_a;
        logic                  ext_b;

        assign lane_a = req_i.operand_a[8*i +: ew_bits(w)];
        assign lane_b = req_i.operand_b[8*i +: ew_bits(w)];

        // Extra top bit is the sign for signed ops, zero otherwise
        assign ext_a = is_signed & lane_a[ew_bits(w)-1];
        assign ext_b = is_signed & lane_b[ew_bits(w)-1];

        assign less_ew[w][i]  = $signed({ext_b, lane_b}) < $signed({ext_a, lane_a});
        assign equal_ew[w][i] = lane_a == lane_b;
      end else begin : g_inner
        assign less_ew[w][i]  = 1'b0;
        assign equal_ew[w][i] = 1'b0;
      end
    end
  end

  assign less_o  = less_ew[req_i.vew];
  assign equal_o = equal_ew[req_i.vew];

endmodule

// ==== rtl/simd_data_pkg.sv ====
package simd_data_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ELEN      = 64;
  localparam int unsigned NUM_BYTES = ELEN / 8;
  // Number of supported element widths from 8 up to 64 bits
  localparam int unsigned NUM_EW    = 4;

  // One operand or result word
  typedef logic [ELEN-1:0] elen_t;

  // One flag per byte of the word
  typedef logic [NUM_BYTES-1:0] byte_flags_t;

  // Byte position inside the word
  typedef logic [$clog2(NUM_BYTES)-1:0] byte_idx_t;

  // Element width
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Bits per element for a width code
  function automatic int unsigned ew_bits(int unsigned ew);
    return 8 << ew;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Request
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    simd_op_pkg::alu_op_e op;
    vew_e                 vew;
    elen_t                operand_a;
    elen_t                operand_b;
  } alu_req_t;

endpackage

// ==== rtl/simd_op_pkg.sv ====
package simd_op_pkg;

  // Kept vector ALU operations
  typedef enum logic [4:0] {
    // Logical
    VAND, VOR, VXOR,
    // Plain arithmetic
    VADD, VSUB, VRSUB,
    // Saturating arithmetic
    VSADDU, VSADD, VSSUBU, VSSUB,
    // Shifts
    VSLL, VSRL, VSRA,
    // Min/max
    VMIN, VMINU, VMAX, VMAXU,
    // Compares
    VMSEQ, VMSNE, VMSLT, VMSLTU, VMSLE, VMSLEU, VMSGT, VMSGTU
  } alu_op_e;

  // Which unit produces the result
  typedef enum logic [1:0] {
    OPC_LOGIC_CMP,
    OPC_ADDSUB,
    OPC_SHIFT
  } op_class_e;

  function automatic op_class_e op_class(alu_op_e op);
    op_class_e cls;
    case (op)
      VADD, VSUB, VRSUB,
      VSADDU, VSADD, VSSUBU, VSSUB: cls = OPC_ADDSUB;
      VSLL, VSRL, VSRA: cls = OPC_SHIFT;
      default: cls = OPC_LOGIC_CMP;
    endcase
    return cls;
  endfunction

  // Ops that compare their lanes as two's complement
  function automatic logic is_signed_op(alu_op_e op);
    return op inside {VMIN, VMAX, VMSLT, VMSLE, VMSGT};
  endfunction

endpackage

// ==== rtl/simd_shift.sv ====
`timescale 1ns/10ps

module simd_shift (
  input  simd_data_pkg::alu_req_t req_i,
  output simd_data_pkg::elen_t    result_o
);
  import simd_data_pkg::*;
  import simd_op_pkg::*;

  elen_t [NUM_EW-1:0] res_ew;

  ////////////////////////////////////////////////////////////////////////////
  // Lane shifters for every width in parallel
  ////////////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_EW; w++) begin : g_ew
    for (genvar l = 0; l < (NUM_BYTES >> w); l++) begin : g_lane
      logic [ew_bits(w)-1:0]         lane_a;
      logic [ew_bits(w)-1:0]         lane_b;
      logic [ew_bits(w)-1:0]         res;
      logic [$clog2(ew_bits(w))-1:0] amt;

      assign lane_a = req_i.operand_a[l*ew_bits(w) +: ew_bits(w)];
      assign lane_b = req_i.operand_b[l*ew_bits(w) +: ew_bits(w)];

      // Shift amount wraps at the element width
      assign amt = lane_a[$clog2(ew_bits(w))-1:0];

      always_comb begin
        case (req_i.op)
          VSLL:    res = lane_b << amt;
          VSRL:    res = lane_b >> amt;
          VSRA:    res = $signed(lane_b) >>> amt;
          default: res = '0;
        endcase
      end

      assign res_ew[w][l*ew_bits(w) +: ew_bits(w)] = res;
    end
  end

  assign result_o = res_ew[req_i.vew];

endmodule

// ==== rtl/simd_writeback.sv ====
`timescale 1ns/10ps

module simd_writeback (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  simd_data_pkg::alu_req_t    req_i,
  input  simd_data_pkg::byte_flags_t less_i,
  input  simd_data_pkg::byte_flags_t equal_i,
  input  simd_data_pkg::elen_t       addsub_i,
  input  simd_data_pkg::byte_flags_t sat_i,
  input  simd_data_pkg::elen_t       shift_i,
  output logic                       valid_o,
  output simd_data_pkg::elen_t       result_o,
  output simd_data_pkg::byte_flags_t vxsat_o
);
  import simd_data_pkg::*;
  import simd_op_pkg::*;

  byte_idx_t   lane_mask;
  byte_flags_t lane_start;
  byte_flags_t less_bc;
  byte_flags_t pred;
  logic        is_max;
  elen_t       minmax_res;
  elen_t       cmp_res;
  elen_t       logic_cmp_res;
  elen_t       next_result;
  byte_flags_t next_sat;

  ////////////////////////////////////////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////////////////////////////////////////

  // Low byte-index bits inside one lane
  assign lane_mask = (byte_idx_t'(1) << req_i.vew) - byte_idx_t'(1);

  always_comb begin
    byte_idx_t base;
    for (int i = 0; i < NUM_BYTES; i++) begin
      base          = byte_idx_t'(i) & ~lane_mask;
      lane_start[i] = base == byte_idx_t'(i);
      // Spread the lane flag over all of its bytes
      less_bc[i]    = less_i[base];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Min/max and compares
  ////////////////////////////////////////////////////////////////////////////

  assign is_max = req_i.op inside {VMAX, VMAXU};

  always_comb begin
    case (req_i.op)
      VMSEQ:         pred = equal_i;
      VMSNE:         pred = ~equal_i & lane_start;
      VMSLT, VMSLTU: pred = less_i;
      VMSLE, VMSLEU: pred = less_i | equal_i;
      VMSGT, VMSGTU: pred = ~(less_i | equal_i) & lane_start;
      default:       pred = '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      minmax_res[8*i +: 8] = (less_bc[i] ^ is_max) ? req_i.operand_b[8*i +: 8]
                                                   : req_i.operand_a[8*i +: 8];
      cmp_res[8*i +: 8]    = {7'b0, pred[i]};
    end
  end

  always_comb begin
    case (req_i.op)
      VAND:                     logic_cmp_res = req_i.operand_a & req_i.operand_b;
      VOR:                      logic_cmp_res = req_i.operand_a | req_i.operand_b;
      VXOR:                     logic_cmp_res = req_i.operand_a ^ req_i.operand_b;
      VMIN, VMINU, VMAX, VMAXU: logic_cmp_res = minmax_res;
      default:                  logic_cmp_res = cmp_res;
    endcase
  end

  // Unit select with flags taken only from the adder
  always_comb begin
    next_sat = '0;
    case (op_class(req_i.op))
      OPC_ADDSUB: begin
        next_result = addsub_i;
        next_sat    = sat_i;
      end
      OPC_SHIFT: next_result = shift_i;
      default:   next_result = logic_cmp_res;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      valid_o  <= valid_i;
      result_o <= valid_i ? next_result : '0;
      vxsat_o  <= valid_i ? next_sat : '0;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the SIMD ALU testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_simd_alu -f list.f -o tb_simd_alu &&
./obj_dir/tb_simd_alu &&
exit 0 ||
exit 1

// ==== sim/simd_alu_asserts.sv ====
`timescale 1ns/10ps

module simd_alu_asserts (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       valid_i,
  input simd_data_pkg::alu_req_t    req_i,
  input logic                       valid_o,
  input simd_data_pkg::elen_t       result_o,
  input simd_data_pkg::byte_flags_t vxsat_o
);
  import simd_op_pkg::*;

  logic sat_req;

  assign sat_req = valid_i && (req_i.op inside {VSADDU, VSADD, VSSUBU, VSSUB});

  valid_low_after_reset: assert property (@(posedge clk_i) reset_i |=> !valid_o)
    else $error("valid_o high in the cycle after reset");

  // One cycle of latency and one result per request
  valid_follows_input: assert property (
    @(posedge clk_i) !reset_i |=> valid_o == $past(valid_i))
    else $error("valid_o does not follow valid_i by one cycle");

  idle_outputs_zero: assert property (
    @(posedge clk_i) disable iff (reset_i) !valid_o |-> (result_o == '0 && vxsat_o == '0))
    else $error("result_o or vxsat_o non-zero while valid_o is low");

  sat_only_from_sat_ops: assert property (
    @(posedge clk_i) !reset_i && !sat_req |=> vxsat_o == '0)
    else $error("vxsat_o set after a non-saturating operation");

endmodule

bind simd_alu simd_alu_asserts u_asserts (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .valid_i  (valid_i),
  .req_i    (req_i),
  .valid_o  (valid_o),
  .result_o (result_o),
  .vxsat_o  (vxsat_o)
);

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for the first 10 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (10) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== sim/tb_simd_alu.sv ====
`timescale 1ns/10ps

module tb_simd_alu;
  import simd_data_pkg::*;
  import simd_op_pkg::*;

  typedef struct packed {
    elen_t       result;
    byte_flags_t vxsat;
  } expect_t;

  logic        clk;
  logic        reset;
  logic        req_valid;
  alu_req_t    alu_req;
  logic        out_valid;
  elen_t       out_result;
  byte_flags_t out_vxsat;
  logic        expect_valid = 1'b0;
  int unsigned cycle_cnt = 0;
  int          seed = 32'hd4b;
  expect_t     exp_q[$];

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  simd_alu dut (
    .clk_i    (clk),
    .reset_i  (reset),
    .valid_i  (req_valid),
    .req_i    (alu_req),
    .valid_o  (out_valid),
    .result_o (out_result),
    .vxsat_o  (out_vxsat)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic elen_t lane_mask(vew_e ew);
    return (ew == EW64) ? '1 : ((elen_t'(1) << (8 << ew)) - elen_t'(1));
  endfunction

  function automatic elen_t splat(vew_e ew, elen_t lane);
    elen_t       word;
    int unsigned bits;
    word = '0;
    bits = 8 << ew;
    for (int l = 0; l < 64 / bits; l++) begin
      word |= (lane & lane_mask(ew)) << (l * bits);
    end
    return word;
  endfunction

  function automatic expect_t ref_alu(alu_req_t req);
    expect_t            exp;
    int unsigned        bits;
    int unsigned        amt;
    elen_t              mask;
    elen_t              a;
    elen_t              b;
    logic signed [65:0] ua;
    logic signed [65:0] ub;
    logic signed [65:0] sa;
    logic signed [65:0] sb;
    logic signed [65:0] t;
    logic signed [65:0] smax;
    logic signed [65:0] smin;
    logic               sgn;
    logic               lt;
    logic               eq;
    logic               sat;
    exp  = '0;
    bits = 8 << req.vew;
    mask = lane_mask(req.vew);
    smax = (66'sd1 <<< (bits - 1)) - 66'sd1;
    smin = -(66'sd1 <<< (bits - 1));
    sgn  = req.op inside {VMIN, VMAX, VMSLT, VMSLE, VMSGT};
    for (int l = 0; l < 64 / bits; l++) begin
      a   = (req.operand_a >> (l * bits)) & mask;
      b   = (req.operand_b >> (l * bits)) & mask;
      ua  = $signed({2'b00, a});
      ub  = $signed({2'b00, b});
      sa  = a[bits-1] ? ua - (66'sd1 <<< bits) : ua;
      sb  = b[bits-1] ? ub - (66'sd1 <<< bits) : ub;
      amt = int'(a[5:0]) & (bits - 1);
      // B < A, signed or unsigned
      lt  = sgn ? (sb < sa) : (ub < ua);
      eq  = a == b;
      sat = 1'b0;
      case (req.op)
        VAND:         t = ua & ub;
        VOR:          t = ua | ub;
        VXOR:         t = ua ^ ub;
        VADD:         t = ua + ub;
        VSUB:         t = ub - ua;
        VRSUB:        t = ua - ub;
        VSADDU: begin
          t   = ua + ub;
          sat = t > $signed({2'b00, mask});
          t   = sat ? $signed({2'b00, mask}) : t;
        end
        VSSUBU: begin
          t   = ub - ua;
          sat = t < 66'sd0;
          t   = sat ? 66'sd0 : t;
        end
        VSADD, VSSUB: begin
          t   = (req.op == VSADD) ? sa + sb : sb - sa;
          sat = (t > smax) || (t < smin);
          t   = (t > smax) ? smax : ((t < smin) ? smin : t);
        end
        VSLL:         t = ub << amt;
        VSRL:         t = ub >> amt;
        VSRA:         t = sb >>> amt;
        VMIN, VMINU:  t = lt ? ub : ua;
        VMAX, VMAXU:  t = lt ? ua : ub;
        VMSEQ:        t = {65'd0, eq};
        VMSNE:        t = {65'd0, !eq};
        VMSLT, VMSLTU: t = {65'd0, lt};
        VMSLE, VMSLEU: t = {65'd0, lt || eq};
        default:      t = {65'd0, !(lt || eq)};
      endcase
      exp.result |= (t[63:0] & mask) << (l * bits);
      if (sat) begin
        exp.vxsat |= byte_flags_t'(((1 << (bits / 8)) - 1) << (l * bits / 8));
      end
    end
    return exp;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: valid_o is %b, expected %b", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_result(input elen_t got, input elen_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: result_o is %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_vxsat(input byte_flags_t got, input byte_flags_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: vxsat_o is %b, expected %b", $time, got, exp);
      stop_run();
    end
  endtask

  always @(posedge clk) begin
    expect_valid <= req_valid && !reset;
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin : compare
    expect_t exp;
    if (!reset) begin
      check_valid(out_valid, expect_valid);
      if (out_valid && exp_q.size() == 0) begin
        $display("valid_o went high at %0t with no request outstanding", $time);
        stop_run();
      end else if (out_valid) begin
        exp = exp_q.pop_front();
        check_result(out_result, exp.result);
        check_vxsat(out_vxsat, exp.vxsat);
      end else begin
        check_result(out_result, '0);
        check_vxsat(out_vxsat, '0);
      end
    end
  end

  // About 10 reset cycles plus 2100 stimulus cycles and some margin
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == 2300) begin
      $display("timeout: the run did not finish within 2300 cycles");
      stop_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic alu_req_t make_req(alu_op_e op, vew_e ew, elen_t a, elen_t b);
    alu_req_t req;
    req.op        = op;
    req.vew       = ew;
    req.operand_a = a;
    req.operand_b = b;
    return req;
  endfunction

  task automatic send_req(input alu_req_t req);
    req_valid <= 1'b1;
    alu_req   <= req;
    exp_q.push_back(ref_alu(req));
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      req_valid <= 1'b0;
      alu_req   <= '0;
      @(posedge clk);
    end
  endtask

  task automatic send_random(input vew_e ew);
    int unsigned r;
    r = $unsigned($random(seed)) % 25;
    send_req(make_req(alu_op_e'(r[4:0]), ew, {$random(seed), $random(seed)},
                      {$random(seed), $random(seed)}));
  endtask

  initial begin
    vew_e  ew;
    elen_t umax_l;
    elen_t smax_l;
    elen_t smin_l;
    elen_t one;
    elen_t pa[3];
    elen_t pb[3];
    elen_t amt[3];
    req_valid <= 1'b0;
    alu_req   <= '0;
    one = elen_t'(1);
    do @(posedge clk); while (reset);

    // Single requests around idle gaps
    send_random(EW8);
    idle_cycles(2);
    send_random(EW16);
    send_random(EW32);
    idle_cycles(1);

    for (int w = 0; w < NUM_EW; w++) begin
      for (int n = 0; n < 400; n++) begin
        send_random(vew_e'(w[1:0]));
        if (($random(seed) & 7) == 0) idle_cycles(1);
      end
    end

    for (int w = 0; w < NUM_EW; w++) begin
      ew     = vew_e'(w[1:0]);
      umax_l = lane_mask(ew);
      smax_l = umax_l >> 1;
      smin_l = smax_l + one;
      // Saturation at the lane extremes
      send_req(make_req(VSADDU, ew, splat(ew, umax_l), splat(ew, one)));
      send_req(make_req(VSADDU, ew, umax_l, splat(ew, one)));
      send_req(make_req(VSADDU, ew, splat(ew, one), splat(ew, one)));
      send_req(make_req(VSSUBU, ew, splat(ew, one), '0));
      send_req(make_req(VSSUBU, ew, '0, splat(ew, umax_l)));
      send_req(make_req(VSADD, ew, splat(ew, smax_l), splat(ew, one)));
      send_req(make_req(VSADD, ew, splat(ew, smin_l), splat(ew, umax_l)));
      send_req(make_req(VSSUB, ew, splat(ew, umax_l), splat(ew, smax_l)));
      send_req(make_req(VSSUB, ew, splat(ew, one), splat(ew, smin_l)));
      send_req(make_req(VSSUB, ew, splat(ew, smin_l), splat(ew, smin_l)));
      // Min/max and compares on equal and sign-bit-only operands
      pa = '{splat(ew, smin_l | one), splat(ew, smin_l), '0};
      pb = '{splat(ew, smin_l | one), '0, splat(ew, smin_l)};
      for (int p = 0; p < 3; p++) begin
        for (int o = int'(VMIN); o <= int'(VMSGTU); o++) begin
          send_req(make_req(alu_op_e'(o[4:0]), ew, pa[p], pb[p]));
        end
      end
      // Every byte negative, so every lane is negative
      amt = '{'0, splat(ew, umax_l >> 1 & elen_t'(63)), splat(ew, elen_t'((8 << w) + 1))};
      for (int s = 0; s < 3; s++) begin
        send_req(make_req(VSLL, ew, amt[s], 64'h9ac5_b3e7_f18d_a4c2));
        send_req(make_req(VSRL, ew, amt[s], 64'h9ac5_b3e7_f18d_a4c2));
        send_req(make_req(VSRA, ew, amt[s], 64'h9ac5_b3e7_f18d_a4c2));
      end
    end

    idle_cycles(3);
    if (exp_q.size() != 0) begin
      $display("%0d requests never produced a valid result", exp_q.size());
      stop_run();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule
